// ==== all.f ====
verilog/vreadPkg.sv
verilog/bufferIf.sv
verilog/burstWriter.sv
verilog/dualPortBuffer.sv
verilog/patternReader.sv
verilog/vreadTop.sv
bench/vreadTb_chk.sv
bench/vreadTb.sv

// ==== bench/vreadTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vreadTb
   import vreadPkg::*;
();

   localparam int DATA_W = 32;
   localparam int MEM_ADDR_W = 8;
   localparam int PERIOD_W = 8;
   localparam int TIMEOUT = 2000;

   logic                  clk;
   logic                  rst;
   logic                  run;
   logic                  pingPong;
   logic [BUS_ADDR_W-1:0] extAddr;
   logic [7:0]            length;
   logic [MEM_ADDR_W-1:0] iterA, shiftA, incrA;
   logic [PERIOD_W-1:0]   perA;
   logic [MEM_ADDR_W-1:0] iterB, startB, shiftB, incrB;
   logic [PERIOD_W-1:0]   perB, delay;
   logic                  reverseB;
   logic                  busAck;
   logic                  busLast;
   logic [DATA_W-1:0]     busData;
   logic                  busReq;
   logic [BUS_ADDR_W-1:0] busAddr;
   logic [7:0]            busLen;
   logic [DATA_W-1:0]     outData;
   logic                  outValid;
   logic                  done;

   // buffer model and expected stream
   logic [DATA_W-1:0] model [256];
   bit                known [256];
   logic [DATA_W-1:0] expQ [$];
   bit                knownQ [$];

   int   errors, checks, idx, beatCnt, readCnt, ackPct;
   bit   runActive, lastBeatSeen, lastValidSeen, timedOut;
   logic ppsModel;

   vreadTop #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W), .PERIOD_W(PERIOD_W)) vreadTop_inst
   (
      .clk(clk), .rst(rst), .run(run), .pingPong(pingPong), .extAddr(extAddr),
      .length(length), .iterA(iterA), .perA(perA), .shiftA(shiftA), .incrA(incrA),
      .iterB(iterB), .perB(perB), .startB(startB), .shiftB(shiftB), .incrB(incrB),
      .reverseB(reverseB), .delay(delay), .busAck(busAck), .busData(busData),
      .busLast(busLast), .busReq(busReq), .busAddr(busAddr), .busLen(busLen),
      .outData(outData), .outValid(outValid), .done(done)
   );

   always #2 clk = ~clk;

   task automatic checkValue(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED %s: got %0h, expected %0h at %0t", name, actual, expected, $time);
      end
   endtask

   function automatic logic [7:0] flipAddr(input logic [7:0] a);
      return {<<{a}};
   endfunction

   // row-major start + row * shift + col * incr wrapped to the buffer size
   function automatic logic [7:0] affineAddr(input logic [7:0] start, input int k, input int per,
                                             input logic [7:0] shift, input logic [7:0] incr);
      int sum;
      sum = int'(start) + (k / per) * int'(shift) + (k % per) * int'(incr);
      return sum[7:0];
   endfunction

   // bus slave with random acknowledge and data
   always @(posedge clk)
   begin
      #1;
      busData = $urandom;
      if (busReq && !rst)
      begin
         busAck  = ($urandom_range(99) < ackPct);
         busLast = busAck && (beatCnt == int'(length));
      end
      else
      begin
         busAck  = 1'b0;
         busLast = 1'b0;
      end
   end

   // mid-cycle monitor and reference model
   always @(negedge clk)
   begin
      logic [7:0] rdAddr;
      logic [7:0] wrAddr;
      logic [7:0] startSel;
      int         n;
      n = int'(iterB) * int'(perB);
      if (!rst && run)
      begin
         idx = 0;
         beatCnt = 0;
         readCnt = 0;
         lastBeatSeen = 0;
         lastValidSeen = 0;
         runActive = 1;
         ppsModel = pingPong ? ~ppsModel : 1'b0;
         checkValue("busReq", busReq, 1'b0);
      end
      else if (!rst && runActive)
      begin
         idx++;
         checkValue("busReq", busReq, !lastBeatSeen);
         checkValue("done", done, lastBeatSeen && lastValidSeen);
         checkValue("outValid", outValid, idx >= int'(delay) + 2 && idx <= int'(delay) + n + 1);
         if (idx == 1)
         begin
            checkValue("busAddr", busAddr, extAddr);
            checkValue("busLen", busLen, length);
         end
         if (outValid)
         begin
            if (expQ.size() == 0)
            begin
               errors++;
               $display("outValid seen with no read pending at %0t", $time);
            end
            else
            begin
               if (knownQ.pop_front())
                  checkValue("outData", outData, expQ.pop_front());
               else
                  void'(expQ.pop_front());
               readCnt++;
               if (readCnt == n)
                  lastValidSeen = 1;
            end
         end
         // read sees the old word when a write hits the same edge
         if (idx >= int'(delay) + 1 && idx <= int'(delay) + n)
         begin
            startSel = pingPong ? {ppsModel, startB[6:0]} : startB;
            rdAddr = affineAddr(startSel, idx - int'(delay) - 1, int'(perB), shiftB, incrB);
            if (reverseB)
               rdAddr = flipAddr(rdAddr);
            expQ.push_back(model[rdAddr]);
            knownQ.push_back(known[rdAddr]);
         end
         if (busReq && busAck)
         begin
            wrAddr = affineAddr({~ppsModel, 7'b0}, beatCnt, int'(perA), shiftA, incrA);
            model[wrAddr] = busData;
            known[wrAddr] = 1;
            beatCnt++;
            if (busLast)
               lastBeatSeen = 1;
         end
      end
   end

   task automatic startRun(input bit pp);
      int waitCnt;
      if (timedOut)
         return;
      pingPong = pp;
      extAddr = $urandom;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      waitCnt = 0;
      while (!done && waitCnt < TIMEOUT)
      begin
         @(posedge clk);
         #1;
         waitCnt++;
      end
      if (!done)
      begin
         errors++;
         timedOut = 1;
         $display("timed out waiting for done after a run");
      end
      else
      begin
         checkValue("readCount", readCnt, int'(iterB) * int'(perB));
         checkValue("pendingReads", expQ.size(), 0);
      end
   endtask

   initial
   begin
      void'($urandom(30));
      clk = 0;
      rst = 1;
      run = 0;
      pingPong = 0;
      extAddr = '0;
      length = 8'd0;
      {iterA, perA, shiftA, incrA} = {8'd1, 8'd1, 8'd0, 8'd0};
      {iterB, perB, startB, shiftB, incrB} = {8'd1, 8'd1, 8'd0, 8'd0, 8'd0};
      reverseB = 0;
      delay = 8'd1;
      busAck = 0;
      busLast = 0;
      busData = '0;
      errors = 0;
      checks = 0;
      runActive = 0;
      timedOut = 0;
      ppsModel = 0;
      ackPct = 100;
      beatCnt = 0;
      foreach (known[i])
         known[i] = 0;
      repeat (2) @(posedge clk);
      #1 rst = 0;
      checkValue("done", done, 1'b1);
      checkValue("busReq", busReq, 1'b0);
      checkValue("outValid", outValid, 1'b0);

      // fill upper half then lower half through a ping-pong run
      {iterA, perA, shiftA, incrA} = {8'd2, 8'd64, 8'd64, 8'd1};
      length = 8'd127;
      {iterB, perB, startB, shiftB, incrB} = {8'd1, 8'd4, 8'h80, 8'd0, 8'd1};
      delay = 8'd200;
      startRun(1'b0);
      startRun(1'b1);

      // random patterns with stalls and reads well after the writes
      for (int n = 0; n < 6; n++)
      begin
         iterA = $urandom_range(4, 1);
         perA = $urandom_range(8, 1);
         shiftA = $urandom;
         incrA = $urandom;
         length = iterA * perA - 8'd1;
         iterB = $urandom_range(4, 1);
         perB = $urandom_range(8, 1);
         startB = $urandom;
         shiftB = $urandom;
         incrB = $urandom;
         reverseB = n[0];
         delay = 8'd200;
         ackPct = $urandom_range(100, 40);
         startRun(1'b0);
      end

      // same pattern each time so a run reads back the previous burst
      {iterA, perA, shiftA, incrA} = {8'd3, 8'd5, 8'd8, 8'd1};
      length = 8'd14;
      {iterB, perB, startB, shiftB, incrB} = {8'd3, 8'd5, 8'd0, 8'd8, 8'd1};
      reverseB = 0;
      for (int n = 0; n < 5; n++)
      begin
         delay = $urandom_range(20, 1);
         ackPct = $urandom_range(100, 40);
         startRun(1'b1);
      end

      repeat (4) @(posedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/vreadTb_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module vreadTb_chk
(
   input wire clk,
   input wire rst,
   input wire busReq,
   input wire busAck,
   input wire busLast,
   input wire done,
   input wire rdEn,
   input wire outValid
);

   // no bus request once the unit is done
   reqWhileDone: assert property (@(posedge clk) disable iff (rst) !(busReq && done))
      else $error("busReq high while done is high");

   // stream strobe tracks the read enable by one cycle
   validAfterRead: assert property (@(posedge clk) disable iff (rst) outValid |-> $past(rdEn))
      else $error("outValid without rdEn in the previous cycle");

   // request ends right after the last beat
   reqDropsAfterLast: assert property (@(posedge clk) disable iff (rst)
      (busReq && busAck && busLast) |=> !busReq)
      else $error("busReq still high after the last beat");

endmodule

bind vreadTop vreadTb_chk chkInst
(
   .clk(clk), .rst(rst), .busReq(busReq), .busAck(busAck), .busLast(busLast),
   .done(done), .rdEn(bufBus.rdEn), .outValid(outValid)
);

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator, the log decides the result
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module vreadTb -o vreadSim \
   && ./obj_dir/vreadSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// ==== verilog/bufferIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bufferIf
#(
   parameter int DATA_W = 32,
   parameter int MEM_ADDR_W = 8
);

   // write port
   logic                  wrEn;
   logic [MEM_ADDR_W-1:0] wrAddr;
   logic [DATA_W-1:0]     wrData;

   // read port, data one cycle after rdEn
   logic                  rdEn;
   logic [MEM_ADDR_W-1:0] rdAddr;
   logic [DATA_W-1:0]     rdData;

   modport writer (output wrEn, output wrAddr, output wrData);

   modport reader (output rdEn, output rdAddr, input rdData);

   modport memory
   (
      input  wrEn,
      input  wrAddr,
      input  wrData,
      input  rdEn,
      input  rdAddr,
      output rdData
   );

endinterface

`default_nettype wire

// ==== verilog/burstWriter.sv ====
`timescale 1ns/100ps
`default_nettype none

module burstWriter
   import vreadPkg::*;
#(
   parameter int DATA_W = 32,
   parameter int MEM_ADDR_W = 8,
   parameter int PERIOD_W = 8
)
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run,
   input  wire                  half,
   input  wire [MEM_ADDR_W-1:0] iterA,
   input  wire [PERIOD_W-1:0]   perA,
   input  wire [MEM_ADDR_W-1:0] shiftA,
   input  wire [MEM_ADDR_W-1:0] incrA,
   input  wire                  busAck,
   input  wire                  busLast,
   input  wire [DATA_W-1:0]     busData,
   output logic                 busReq,
   output logic                 busDone,
   bufferIf.writer              bufIf
);

   genState_t state;

   logic [PERIOD_W-1:0]   col;
   logic [MEM_ADDR_W-1:0] row;
   logic [MEM_ADDR_W-1:0] rowBase;
   logic [MEM_ADDR_W-1:0] offset;
   logic [MEM_ADDR_W-1:0] startA;
   logic                  beat;
   logic                  colEnd;
   logic                  rowEnd;

   // writer fills the half the reader is not using
   assign startA = {~half, {(MEM_ADDR_W-1){1'b0}}};

   assign beat   = busReq & busAck;
   assign colEnd = (col == perA - 1'b1);
   assign rowEnd = (row == iterA - 1'b1);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= GEN_IDLE;
         col     <= '0;
         row     <= '0;
         rowBase <= '0;
         offset  <= '0;
      end
      else if (run)
      begin
         state   <= GEN_RUN;
         col     <= '0;
         row     <= '0;
         rowBase <= '0;
         offset  <= '0;
      end
      else if (beat)
      begin
         // burst length comes from the slave, not from the pattern
         if (busLast)
            state <= GEN_IDLE;
         if (colEnd)
         begin
            col <= '0;
            if (rowEnd)
            begin
               // pattern exhausted, start over
               row     <= '0;
               rowBase <= '0;
               offset  <= '0;
            end
            else
            begin
               row     <= row + 1'b1;
               rowBase <= rowBase + shiftA;
               offset  <= rowBase + shiftA;
            end
         end
         else
         begin
            col    <= col + 1'b1;
            offset <= offset + incrA;
         end
      end
   end

   assign busReq  = (state == GEN_RUN);
   assign busDone = beat & busLast;

   // word is written at the edge that ends the beat
   assign bufIf.wrEn   = beat;
   assign bufIf.wrAddr = startA + offset;
   assign bufIf.wrData = busData;

endmodule

`default_nettype wire

// ==== verilog/dualPortBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dualPortBuffer
#(
   parameter int DATA_W = 32,
   parameter int MEM_ADDR_W = 8
)
(
   input  wire        clk,
   bufferIf.memory    mem
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;

   logic [DATA_W-1:0] memArray [DEPTH];
   logic [DATA_W-1:0] rdQ;

   // same-address read during a write returns the old word
   always_ff @(posedge clk)
   begin
      if (mem.wrEn)
         memArray[mem.wrAddr] <= mem.wrData;
      if (mem.rdEn)
         rdQ <= memArray[mem.rdAddr];
   end

   assign mem.rdData = rdQ;

endmodule

`default_nettype wire

// ==== verilog/patternReader.sv ====
`timescale 1ns/100ps
`default_nettype none

module patternReader
   import vreadPkg::*;
#(
   parameter int DATA_W = 32,
   parameter int MEM_ADDR_W = 8,
   parameter int PERIOD_W = 8
)
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run,
   input  wire [MEM_ADDR_W-1:0] iterB,
   input  wire [PERIOD_W-1:0]   perB,
   input  wire [MEM_ADDR_W-1:0] startB,
   input  wire [MEM_ADDR_W-1:0] shiftB,
   input  wire [MEM_ADDR_W-1:0] incrB,
   input  wire                  reverseB,
   input  wire [PERIOD_W-1:0]   delay,
   output logic [DATA_W-1:0]    outData,
   output logic                 outValid,
   output logic                 readDone,
   bufferIf.reader              bufIf
);

   genState_t state;

   logic [PERIOD_W-1:0]   delayCnt;
   logic [PERIOD_W-1:0]   col;
   logic [MEM_ADDR_W-1:0] row;
   logic [MEM_ADDR_W-1:0] rowBase;
   logic [MEM_ADDR_W-1:0] offset;
   logic [MEM_ADDR_W-1:0] rawAddr;
   logic                  rdEn;
   logic                  colEnd;
   logic                  rowEnd;
   logic                  lastRead;
   logic                  validQ;
   logic                  lastQ;

   function automatic logic [MEM_ADDR_W-1:0] reverseBits(input logic [MEM_ADDR_W-1:0] word);
      logic [MEM_ADDR_W-1:0] result;
      for (int i = 0; i < MEM_ADDR_W; i++)
         result[i] = word[MEM_ADDR_W-1-i];
      return result;
   endfunction

   assign rdEn     = (state == GEN_RUN);
   assign colEnd   = (col == perB - 1'b1);
   assign rowEnd   = (row == iterB - 1'b1);
   assign lastRead = rdEn & colEnd & rowEnd;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= GEN_IDLE;
         delayCnt <= '0;
         col      <= '0;
         row      <= '0;
         rowBase  <= '0;
         offset   <= '0;
      end
      else if (run)
      begin
         // zero delay goes straight to reading
         state    <= (delay == '0) ? GEN_RUN : GEN_DELAY;
         delayCnt <= delay;
         col      <= '0;
         row      <= '0;
         rowBase  <= '0;
         offset   <= '0;
      end
      else
      begin
         case (state)
            GEN_DELAY:
            begin
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == 1)
                  state <= GEN_RUN;
            end
            GEN_RUN:
            begin
               if (colEnd)
               begin
                  col <= '0;
                  if (rowEnd)
                     state <= GEN_IDLE;
                  else
                  begin
                     row     <= row + 1'b1;
                     rowBase <= rowBase + shiftB;
                     offset  <= rowBase + shiftB;
                  end
               end
               else
               begin
                  col    <= col + 1'b1;
                  offset <= offset + incrB;
               end
            end
            default:
            begin
               state <= GEN_IDLE;
            end
         endcase
      end
   end

   // valid pipeline matches the memory read latency
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         validQ <= 1'b0;
         lastQ  <= 1'b0;
      end
      else
      begin
         validQ <= rdEn;
         lastQ  <= lastRead;
      end
   end

   assign rawAddr = startB + offset;

   assign bufIf.rdEn   = rdEn;
   assign bufIf.rdAddr = reverseB ? reverseBits(rawAddr) : rawAddr;

   assign outData  = bufIf.rdData;
   assign outValid = validQ;
   assign readDone = lastQ;

endmodule

`default_nettype wire

// ==== verilog/vreadPkg.sv ====
`default_nettype none

package vreadPkg;

   // external databus address width
   localparam int BUS_ADDR_W = 32;

   // shared by both address generators
   // the writer never uses GEN_DELAY
   typedef enum logic [1:0]
   {
      GEN_IDLE  = 2'd0,
      GEN_DELAY = 2'd1,
      GEN_RUN   = 2'd2
   } genState_t;

endpackage

`default_nettype wire

// ==== verilog/vreadTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module vreadTop
   import vreadPkg::*;
#(
   parameter int DATA_W = 32,
   parameter int MEM_ADDR_W = 8,
   parameter int PERIOD_W = 8
)
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run,
   input  wire                  pingPong,
   input  wire [BUS_ADDR_W-1:0] extAddr,
   input  wire [7:0]            length,
   // write side
   input  wire [MEM_ADDR_W-1:0] iterA,
   input  wire [PERIOD_W-1:0]   perA,
   input  wire [MEM_ADDR_W-1:0] shiftA,
   input  wire [MEM_ADDR_W-1:0] incrA,
   // read side
   input  wire [MEM_ADDR_W-1:0] iterB,
   input  wire [PERIOD_W-1:0]   perB,
   input  wire [MEM_ADDR_W-1:0] startB,
   input  wire [MEM_ADDR_W-1:0] shiftB,
   input  wire [MEM_ADDR_W-1:0] incrB,
   input  wire                  reverseB,
   input  wire [PERIOD_W-1:0]   delay,
   // databus
   input  wire                  busAck,
   input  wire [DATA_W-1:0]     busData,
   input  wire                  busLast,
   output logic                 busReq,
   output logic [BUS_ADDR_W-1:0] busAddr,
   output logic [7:0]           busLen,
   // stream
   output logic [DATA_W-1:0]    outData,
   output logic                 outValid,
   output logic                 done
);

   logic                  pingPongState;
   logic [MEM_ADDR_W-1:0] startSel;
   logic                  busDone;
   logic                  readDone;
   logic                  busFin;
   logic                  readFin;

   bufferIf #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W)) bufBus ();

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pingPongState <= 1'b0;
         busAddr       <= '0;
         busLen        <= '0;
         busFin        <= 1'b1;
         readFin       <= 1'b1;
      end
      else if (run)
      begin
         pingPongState <= pingPong ? ~pingPongState : 1'b0;
         busAddr       <= extAddr;
         busLen        <= length;
         busFin        <= 1'b0;
         readFin       <= 1'b0;
      end
      else
      begin
         if (busDone)
            busFin <= 1'b1;
         if (readDone)
            readFin <= 1'b1;
      end
   end

   // reader takes the half the previous run filled
   assign startSel = pingPong ? {pingPongState, startB[MEM_ADDR_W-2:0]} : startB;

   assign done = busFin & readFin;

   burstWriter #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W), .PERIOD_W(PERIOD_W)) writer_inst
   (
      .clk(clk), .rst(rst), .run(run), .half(pingPongState),
      .iterA(iterA), .perA(perA), .shiftA(shiftA), .incrA(incrA),
      .busAck(busAck), .busLast(busLast), .busData(busData),
      .busReq(busReq), .busDone(busDone), .bufIf(bufBus.writer)
   );

   dualPortBuffer #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W)) buffer_inst
   (
      .clk(clk), .mem(bufBus.memory)
   );

   patternReader #(.DATA_W(DATA_W), .MEM_ADDR_W(MEM_ADDR_W), .PERIOD_W(PERIOD_W)) reader_inst
   (
      .clk(clk), .rst(rst), .run(run),
      .iterB(iterB), .perB(perB), .startB(startSel), .shiftB(shiftB), .incrB(incrB),
      .reverseB(reverseB), .delay(delay),
      .outData(outData), .outValid(outValid), .readDone(readDone), .bufIf(bufBus.reader)
   );

endmodule

`default_nettype wire
